//--- source/ita_package.sv
/*
  Shared widths, lane count and types of the requantizing dot-product engine
  Mode and controller state enums, lane vectors and the requant settings struct
*/

package ita_package;

  // Lane count and datapath widths
  localparam int unsigned N   = 4;
  localparam int unsigned WI  = 8;   // Activations, weights, bias, outputs
  localparam int unsigned WO  = 24;  // Accumulator and lane result
  localparam int unsigned EMS = 8;   // Multiplier and shift constants

  // How the lane result is read before scaling
  typedef enum logic {
    Signed   = 1'b0,
    Unsigned = 1'b1
  } requant_mode_e;

  typedef enum logic {
    Idle  = 1'b0,
    Accum = 1'b1
  } ctrl_state_e;

  typedef logic [EMS-1:0] requant_const_t;

  // Per-lane vectors, lane i in slice [i]
  typedef logic signed [N-1:0][WI-1:0] inp_t;
  typedef logic [N-1:0][WO-1:0]        oup_t;
  typedef logic signed [N-1:0][WI-1:0] requant_oup_t;

  // Tile settings, sampled with the last beat
  typedef struct packed {
    requant_mode_e  mode;
    requant_const_t eps_mult;
    requant_const_t right_shift;
  } requant_cfg_t;

endpackage

//--- source/ita_dotp_array.sv
/*
  Per-lane multiply-accumulate over a tile of beats
  Holds the finished tile result, settings and bias for the requantizer
*/

`timescale 1ns/1ps

module ita_dotp_array
  import ita_package::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         in_valid_i,
  input  logic         in_last_i,
  input  logic         acc_clear_i,
  input  inp_t         act_i,
  input  inp_t         wgt_i,
  input  requant_cfg_t cfg_i,
  input  inp_t         bias_i,
  output oup_t         result_o,
  output requant_cfg_t cfg_o,
  output inp_t         bias_o
);

  logic signed [2*WI-1:0] prod [N];
  oup_t                   acc_d, acc_q;
  oup_t                   result_q;
  requant_cfg_t           cfg_q;
  inp_t                   bias_q;
  logic                   last_beat;

  assign last_beat = in_valid_i & in_last_i;

  always_comb begin
    acc_d = acc_q;
    for (int i = 0; i < N; i++) begin
      prod[i] = signed'(act_i[i]) * signed'(wgt_i[i]);
      // First beat of a tile starts a fresh sum
      if (acc_clear_i) begin
        acc_d[i] = WO'(prod[i]);
      end else begin
        acc_d[i] = acc_q[i] + WO'(prod[i]);
      end
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (in_valid_i) begin
      acc_q <= acc_d;
    end
  end

  // Second copy frees the accumulator for the next tile
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      result_q <= '0;
      cfg_q    <= '0;
      bias_q   <= '0;
    end else if (last_beat) begin
      result_q <= acc_d;
      cfg_q    <= cfg_i;
      bias_q   <= bias_i;
    end
  end

  assign result_o = result_q;
  assign cfg_o    = cfg_q;
  assign bias_o   = bias_q;

  a_last_needs_valid : assert property (
    @(posedge clk_i) disable iff (!rst_ni) in_last_i |-> in_valid_i
  ) else $error("in_last_i high without in_valid_i");

endmodule

//--- source/ita_controller.sv
/*
  Tile state machine and the pulse chain that times the requantizer
  and the output strobe after each last beat
*/

`timescale 1ns/1ps

module ita_controller
  import ita_package::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic in_valid_i,
  input  logic in_last_i,
  output logic acc_clear_o,
  output logic tile_done_o,
  output logic calc_en_q_o,
  output logic out_valid_o
);

  ctrl_state_e state_d, state_q;
  logic        done_q;
  logic        calc_q;
  logic        valid_q;

  always_comb begin
    state_d = state_q;
    if (in_valid_i) begin
      if (in_last_i) begin
        state_d = Idle;
      end else begin
        state_d = Accum;
      end
    end
  end

  // Any beat seen in Idle opens a new tile
  assign acc_clear_o = in_valid_i & (state_q == Idle);

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // One bit per tile in flight that shifts every cycle
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      done_q  <= 1'b0;
      calc_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      done_q  <= in_valid_i & in_last_i; // Stage 1 enable
      calc_q  <= done_q;                 // Stage 2 enable
      valid_q <= calc_q;
    end
  end

  assign tile_done_o = done_q;
  assign calc_en_q_o = calc_q;
  assign out_valid_o = valid_q;

  a_valid_latency : assert property (
    @(posedge clk_i) disable iff (!rst_ni) out_valid_o == $past(tile_done_o, 2)
  ) else $error("out_valid_o not two cycles after tile_done_o");

endmodule

//--- source/ita_requantizer.sv
/*
  Two-stage requantizer with scale, arithmetic shift and rounding
  followed by bias add and saturation to the 8-bit output range
*/

`timescale 1ns/1ps

module ita_requantizer
  import ita_package::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  requant_cfg_t cfg_i,
  input  logic         calc_en_i,
  input  logic         calc_en_q_i,
  input  oup_t         result_i,
  input  inp_t         add_i,
  output requant_oup_t requant_oup_o
);

  localparam logic signed [WI-1:0] SAT_MAX = {1'b0, {(WI-1){1'b1}}};
  localparam logic signed [WI-1:0] SAT_MIN = {1'b1, {(WI-1){1'b0}}};

  logic signed [WO:0]       mult_op   [N];
  logic signed [EMS+WO:0]   product   [N];
  logic signed [EMS+WO:0]   round_src [N];
  logic signed [EMS+WO:0]   shifted_d [N];
  logic signed [EMS+WO:0]   shifted_q [N];
  logic signed [EMS+WO+1:0] sum       [N];
  inp_t                     add_q;
  requant_oup_t             requant_oup_d, requant_oup_q;

  // Stage 1
  always_comb begin
    for (int i = 0; i < N; i++) begin
      if (cfg_i.mode == Unsigned) begin
        mult_op[i] = {1'b0, result_i[i]}; // Zero-extend
      end else begin
        mult_op[i] = signed'(result_i[i]);
      end
      product[i]   = signed'({1'b0, cfg_i.eps_mult}) * mult_op[i];
      shifted_d[i] = product[i] >>> cfg_i.right_shift;
      // Last bit shifted out rounds up
      round_src[i] = product[i] >>> (cfg_i.right_shift - 1'b1);
      if ((cfg_i.right_shift != '0) && round_src[i][0]) begin
        shifted_d[i] = shifted_d[i] + 1'b1;
      end
    end
  end

  // Stage 2
  always_comb begin
    for (int i = 0; i < N; i++) begin
      sum[i] = shifted_q[i] + signed'(add_q[i]);
      if (sum[i] > SAT_MAX) begin
        requant_oup_d[i] = SAT_MAX;
      end else if (sum[i] < SAT_MIN) begin
        requant_oup_d[i] = SAT_MIN;
      end else begin
        requant_oup_d[i] = sum[i][WI-1:0];
      end
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      shifted_q <= '{default: '0};
      add_q     <= '0;
    end else if (calc_en_i) begin
      shifted_q <= shifted_d;
      add_q     <= add_i; // Bias follows its tile
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      requant_oup_q <= '0;
    end else if (calc_en_q_i) begin
      requant_oup_q <= requant_oup_d;
    end
  end

  assign requant_oup_o = requant_oup_q;

  a_stage_order : assert property (
    @(posedge clk_i) disable iff (!rst_ni) calc_en_q_i == $past(calc_en_i)
  ) else $error("calc_en_q_i does not follow calc_en_i by one cycle");

endmodule

//--- source/ita_requant_top.sv
/*
  Top level of the requantizing dot-product engine
  Controller, MAC array and requantizer
*/

`timescale 1ns/1ps

module ita_requant_top
  import ita_package::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         in_valid_i,
  input  logic         in_last_i,
  input  inp_t         act_i,
  input  inp_t         wgt_i,
  input  requant_cfg_t cfg_i,
  input  inp_t         bias_i,
  output logic         out_valid_o,
  output requant_oup_t out_data_o
);

  logic         acc_clear;
  logic         tile_done;
  logic         calc_en_q;
  oup_t         result;
  requant_cfg_t tile_cfg;  // Settings of the finished tile
  inp_t         tile_bias;

  ita_controller u_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid_i),
    .in_last_i   (in_last_i),
    .acc_clear_o (acc_clear),
    .tile_done_o (tile_done),
    .calc_en_q_o (calc_en_q),
    .out_valid_o (out_valid_o)
  );

  ita_dotp_array u_dotp (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid_i),
    .in_last_i   (in_last_i),
    .acc_clear_i (acc_clear),
    .act_i       (act_i),
    .wgt_i       (wgt_i),
    .cfg_i       (cfg_i),
    .bias_i      (bias_i),
    .result_o    (result),
    .cfg_o       (tile_cfg),
    .bias_o      (tile_bias)
  );

  ita_requantizer u_requant (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg_i         (tile_cfg),
    .calc_en_i     (tile_done),
    .calc_en_q_i   (calc_en_q),
    .result_i      (result),
    .add_i         (tile_bias),
    .requant_oup_o (out_data_o)
  );

endmodule

//--- testbench/ita_requant_tb.sv
/*
  Testbench of the requantizing dot-product engine
  Clock, reset, tile table, reference model, output monitor and report
*/

`timescale 1ns/1ps

module ita_requant_tb
  import ita_package::*;
;

  localparam int NUM_TILES = 14;

  // One table row per tile
  typedef struct packed {
    int unsigned  beats;
    int unsigned  gap;     // Idle cycles before the tile
    bit           fixed;   // Fixed act and wgt when set
    requant_cfg_t cfg;
    inp_t         bias;
    inp_t         act;
    inp_t         wgt;
  } tile_t;

  typedef struct packed {
    int           idx;
    int           edge_n;  // Edge that samples the last beat
    requant_oup_t data;
  } exp_t;

  logic         clk_i;
  logic         rst_ni;
  logic         in_valid_i;
  logic         in_last_i;
  inp_t         act_i;
  inp_t         wgt_i;
  requant_cfg_t cfg_i;
  inp_t         bias_i;
  logic         out_valid_o;
  requant_oup_t out_data_o;

  tile_t       tiles [NUM_TILES];
  exp_t        exp_q [$];
  int          cycle_cnt = 0;
  int          pass_cnt  = 0;
  int          fail_cnt  = 0;
  int          err_cnt   = 0;
  bit          timed_out = 1'b0;

  ita_requant_top u_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid_i),
    .in_last_i   (in_last_i),
    .act_i       (act_i),
    .wgt_i       (wgt_i),
    .cfg_i       (cfg_i),
    .bias_i      (bias_i),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  function automatic tile_t tile_entry(int unsigned beats, requant_mode_e mode,
                                       logic [7:0] eps, logic [7:0] shift, inp_t bias,
                                       int unsigned gap, bit fixed, inp_t act, inp_t wgt);
    tile_t t;
    t.beats = beats;
    t.gap   = gap;
    t.fixed = fixed;
    t.cfg.mode        = mode;
    t.cfg.eps_mult    = eps;
    t.cfg.right_shift = shift;
    t.bias = bias;
    t.act  = act;
    t.wgt  = wgt;
    return t;
  endfunction

  // Scale, floor shift, round on last bit out, bias, clamp
  function automatic logic [WI-1:0] requant_lane(logic [WO-1:0] acc, requant_cfg_t cfg,
                                                 logic [WI-1:0] bias);
    longint      val;
    longint      prod;
    longint      div;
    longint      q;
    logic [63:0] bits;
    if (cfg.mode == Unsigned) begin
      val = acc;            // Read as 24-bit unsigned
    end else begin
      val = $signed(acc);
    end
    prod = val * longint'(cfg.eps_mult);
    div  = longint'(1) << cfg.right_shift;
    q    = prod / div;
    if ((prod < 0) && (q * div != prod)) begin
      q = q - 1;            // Division truncates toward zero
    end
    bits = prod;
    if (cfg.right_shift != 0) begin
      q = q + longint'(bits[cfg.right_shift-1]);
    end
    q = q + longint'($signed(bias));
    if (q > 127) begin
      q = 127;
    end else if (q < -128) begin
      q = -128;
    end
    return q[WI-1:0];
  endfunction

  task automatic fill_table();
    // Random multi-beat tiles with mid-range scaling
    tiles[0]  = tile_entry(4, Signed, 16, 12, 32'h05FB0010, 3, 0, '0, '0);
    tiles[1]  = tile_entry(3, Signed, 40, 14, 32'h00000000, 1, 0, '0, '0);
    // Rounding with last bit out set, then mostly clear, then no shift
    tiles[2]  = tile_entry(1, Signed, 1, 1, '0, 2, 1, 32'hF9070503, 32'h01010101);
    tiles[3]  = tile_entry(1, Signed, 1, 2, '0, 0, 1, 32'h06F80904, 32'h01010101);
    tiles[4]  = tile_entry(2, Signed, 1, 0, 32'h01020304, 1, 1, 32'hFF28EC0A, 32'h02020202);
    // Saturation both ways by scale and by bias
    tiles[5]  = tile_entry(4, Signed, 255, 4, 32'h64646464, 2, 1, 32'h7F7F7F7F, 32'h7F7F7F7F);
    tiles[6]  = tile_entry(4, Signed, 255, 4, 32'h9C9C9C9C, 0, 1, 32'h80808080, 32'h7F7F7F7F);
    tiles[7]  = tile_entry(1, Signed, 1, 0, 32'h9C649C64, 1, 1, 32'hF60AF60A, 32'h0A0A0A0A);
    tiles[8]  = tile_entry(2, Unsigned, 4, 2, '0, 2, 1, 32'h02FD05FF, 32'h01010101);
    // Back-to-back tiles with up to three in flight
    tiles[9]  = tile_entry(1, Signed, 20, 10, 32'h00000000, 3, 0, '0, '0);
    tiles[10] = tile_entry(1, Signed, 64, 9, 32'h10F01020, 0, 0, '0, '0);
    tiles[11] = tile_entry(2, Signed, 7, 8, 32'hE0203040, 0, 0, '0, '0);
    tiles[12] = tile_entry(1, Signed, 3, 5, 32'h7F807F80, 0, 0, '0, '0);
    tiles[13] = tile_entry(1, Signed, 128, 11, 32'h00010203, 0, 0, '0, '0);
  endtask

  task automatic apply_tile(input tile_t t, input int idx);
    longint sum [N];
    longint prod;
    exp_t   e;
    repeat (t.gap) begin
      in_valid_i = 1'b0;
      in_last_i  = 1'b0;
      @(posedge clk_i);
      #2;
    end
    for (int b = 0; b < t.beats; b++) begin
      if (t.fixed) begin
        act_i = t.act;
        wgt_i = t.wgt;
      end else begin
        act_i = $urandom();
        wgt_i = $urandom();
      end
      in_valid_i = 1'b1;
      in_last_i  = (b == t.beats - 1);
      // Settings only count on the last beat
      cfg_i  = in_last_i ? t.cfg : requant_cfg_t'($urandom());
      bias_i = in_last_i ? t.bias : inp_t'($urandom());
      for (int i = 0; i < N; i++) begin
        prod   = longint'($signed(act_i[i])) * longint'($signed(wgt_i[i]));
        sum[i] = (b == 0) ? prod : sum[i] + prod;
      end
      if (in_last_i) begin
        e.idx    = idx;
        e.edge_n = cycle_cnt + 1;
        for (int i = 0; i < N; i++) begin
          e.data[i] = requant_lane(sum[i][WO-1:0], t.cfg, t.bias[i]);
        end
        exp_q.push_back(e);
      end
      @(posedge clk_i);
      #2;
    end
    in_valid_i = 1'b0;
    in_last_i  = 1'b0;
  endtask

  // Outputs checked at the falling edge
  always @(negedge clk_i) begin : output_monitor
    exp_t e;
    bit   ok;
    if (out_valid_o) begin
      assert (exp_q.size() != 0) else begin
        $display("Unexpected out_valid_o at %0t with no tile pending", $time);
        err_cnt++;
      end
      if (exp_q.size() != 0) begin
        e  = exp_q.pop_front();
        ok = 1'b1;
        assert (cycle_cnt == e.edge_n + 2) else begin
          $display("Tile %0d output came %0d edges after its last beat instead of 3",
                   e.idx, cycle_cnt + 1 - e.edge_n);
          ok = 1'b0;
        end
        for (int i = 0; i < N; i++) begin
          assert (out_data_o[i] == e.data[i]) else begin
            $display("Mismatch at %0t: tile %0d lane %0d got %0d expected %0d", $time,
                     e.idx, i, $signed(out_data_o[i]), $signed(e.data[i]));
            ok = 1'b0;
          end
        end
        if (ok) begin
          pass_cnt++;
          $display("Tile %0d done, output correct", e.idx);
        end else begin
          fail_cnt++;
          $display("Tile %0d done, output wrong", e.idx);
        end
      end
    end else if (exp_q.size() != 0) begin
      assert (cycle_cnt <= exp_q[0].edge_n + 2) else begin
        e = exp_q.pop_front();
        $display("Tile %0d never raised out_valid_o at its expected cycle", e.idx);
        fail_cnt++;
      end
    end
  end

  initial begin
    rst_ni     = 1'b0;
    in_valid_i = 1'b0;
    in_last_i  = 1'b0;
    act_i      = '0;
    wgt_i      = '0;
    cfg_i      = '0;
    bias_i     = '0;
    void'($urandom(32'h48a5));
    fill_table();
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    for (int k = 0; k < NUM_TILES; k++) begin
      apply_tile(tiles[k], k);
    end
    for (int w = 0; (w < 20) && (exp_q.size() != 0); w++) begin
      @(posedge clk_i);
    end
    timed_out = (exp_q.size() != 0);
    repeat (2) @(posedge clk_i);  // Catch stray strobes
    if (timed_out) begin
      $display("Timeout: %0d tile outputs still pending after 20 cycles", exp_q.size());
    end
    $display("Tiles passed %0d, failed %0d, other errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (!timed_out && (fail_cnt == 0) && (err_cnt == 0) && (pass_cnt == NUM_TILES)) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- sim.f
source/ita_package.sv
source/ita_dotp_array.sv
source/ita_controller.sv
source/ita_requantizer.sv
source/ita_requant_top.sv
testbench/ita_requant_tb.sv
